// File: bench/eeprom_stimulus.txt
# rd chan addr data nack, all hex
# data is the write data when rd is 0 and the expected read data when rd is 1
0 0 012 5a 0
1 0 012 5a 0
0 1 034 11 0
0 1 134 22 0
0 1 734 77 0
1 1 034 11 0
1 1 134 22 0
1 1 734 77 0
0 0 100 c3 0
0 1 200 3c 0
0 2 300 a5 0
1 0 100 c3 0
1 1 200 3c 0
1 2 300 a5 0
0 3 055 99 1
1 3 055 00 1
1 0 012 5a 0
1 2 300 a5 0
0 2 7ff 81 0
0 0 7ff 18 0
1 2 7ff 81 0
1 0 7ff 18 0
0 1 0ff e7 0
1 1 0ff e7 0
1 3 7ff 00 1
1 1 034 11 0
1 2 7ff 81 0
0 3 000 42 1

// File: vlog.f
+incdir+common
common/eeprom_pkg.sv
design/eeprom_cmd_dispatch.sv
eeprom_ctrl/eeprom_bit_engine.sv
eeprom_ctrl/eeprom_ctrl.sv
design/eeprom_resp_collect.sv
design/eeprom_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --timing --assert
SIM_FLAGS  := --binary -j 0
TOP        := tb_eeprom_top
FILELIST   := vlog.f
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_eeprom_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module tb_eeprom_top
    import eeprom_pkg::*;
();

    localparam int MAX_LINES = 64;

    logic               CLK = 1'b0;
    logic               RESET;
    logic               req_valid;
    logic               req_ready;
    eeprom_req_t        req;
    logic               rsp_valid;
    logic               rsp_ready = 1'b0;
    eeprom_rsp_t        rsp;
    logic [`NUM_CH-1:0] scl;
    logic [`NUM_CH-1:0] sda_pull;
    logic [`NUM_CH-1:0] sda_in;
    logic [`NUM_CH-1:0] model_pull;
    logic [`NUM_CH-1:0] sda_line;

    eeprom_req_t        stim_req [MAX_LINES];
    logic [`DATA_W-1:0] stim_data [MAX_LINES];
    logic               stim_nack [MAX_LINES];
    int                 n_lines = 0;
    logic               loaded = 1'b0;

    chan_rsp_t          exp_q [`NUM_CH][$];   // filled in file order
    int                 exp_head [`NUM_CH];
    int                 req_count = 0;
    int                 rsp_count = 0;
    int                 err_count = 0;
    logic [15:0]        lfsr = 16'd81;

    initial
    begin
        forever #20 CLK = ~CLK;
    end

    eeprom_top u_eeprom_top (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

    // open-drain bus with pull-ups, channel 3 has no part fitted
    for (genvar i = 0; i < `NUM_CH; i++)
    begin : g_bus
        assign sda_line[i] = !(sda_pull[i] || model_pull[i]);
        eeprom_model #(.PRESENT(i != 3)) u_model (
            .scl      (scl[i]),
            .sda      (sda_line[i]),
            .sda_pull (model_pull[i])
        );
    end
    assign sda_in = sda_line;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    always @(negedge CLK)
    begin
        lfsr      = lfsr_next(lfsr);
        rsp_ready = lfsr[0];
    end

    task automatic load_stimulus(output logic opened);
        int    fd;
        int    code;
        int    rd;
        int    ch;
        int    addr;
        int    data;
        int    nack;
        string line;
        fd     = $fopen("bench/eeprom_stimulus.txt", "r");
        opened = (fd != 0);
        if (opened)
        begin
            while (!$feof(fd))
            begin
                line = "";
                code = $fgets(line, fd);
                code = $sscanf(line, "%h %h %h %h %h", rd, ch, addr, data, nack);
                if (code == 5 && n_lines < MAX_LINES)   // comment lines give 0
                begin
                    stim_req[n_lines].rd    = rd[0];
                    stim_req[n_lines].chan  = `CH_W'(ch);
                    stim_req[n_lines].addr  = `ADDR_W'(addr);
                    stim_req[n_lines].wdata = rd[0] ? '0 : `DATA_W'(data);
                    stim_data[n_lines]      = `DATA_W'(data);
                    stim_nack[n_lines]      = nack[0];
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
    endtask

    task automatic drive_request(input int idx);
        eeprom_req_t r;
        chan_rsp_t   e;
        r       = stim_req[idx];
        e.rd    = r.rd;
        e.addr  = r.addr;
        e.rdata = stim_data[idx];
        e.nack  = stim_nack[idx];
        exp_q[r.chan].push_back(e);
        @(negedge CLK);
        req_valid = 1'b1;
        req       = r;
        @(posedge CLK);
        while (!req_ready)
            @(posedge CLK);
        req_count++;
    endtask

    task automatic check_response(input eeprom_rsp_t r);
        chan_rsp_t e;
        rsp_count++;
        if (exp_head[r.chan] >= exp_q[r.chan].size())
        begin
            err_count++;
            $display("ERROR at %0t: unexpected response on channel %0d addr %h",
                     $time, r.chan, r.addr);
        end
        else
        begin
            e = exp_q[r.chan][exp_head[r.chan]];
            exp_head[r.chan]++;
            if (r.rd != e.rd || r.addr != e.addr)
            begin
                err_count++;
                $display("ERROR at %0t: ch %0d got rd %0d addr %h, expected rd %0d addr %h",
                         $time, r.chan, r.rd, r.addr, e.rd, e.addr);
            end
            if (r.nack != e.nack)
            begin
                err_count++;
                $display("ERROR at %0t: ch %0d addr %h nack %0d, expected %0d",
                         $time, r.chan, r.addr, r.nack, e.nack);
            end
            if (e.rd && !e.nack && r.rdata != e.rdata)
            begin
                err_count++;
                $display("ERROR at %0t: ch %0d addr %h read %h, expected %h",
                         $time, r.chan, r.addr, r.rdata, e.rdata);
            end
        end
    endtask

    // sampled at the edge where the transfer happens
    always @(posedge CLK)
    begin
        if (!RESET && rsp_valid && rsp_ready)
            check_response(rsp);
    end

    task automatic report_and_finish();
        int total;
        total = err_count;
        for (int c = 0; c < `NUM_CH; c++)
        begin
            if (exp_head[c] != exp_q[c].size())
            begin
                total++;
                $display("channel %0d still waits for %0d responses", c,
                         exp_q[c].size() - exp_head[c]);
            end
        end
        if (rsp_count != req_count)
        begin
            total++;
            $display("got %0d responses for %0d requests", rsp_count, req_count);
        end
        $display("requests %0d responses %0d errors %0d", req_count, rsp_count, total);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    endtask

    initial
    begin
        logic opened;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        for (int c = 0; c < `NUM_CH; c++)
            exp_head[c] = 0;
        load_stimulus(opened);
        if (!opened || n_lines == 0)
        begin
            $display("stimulus file bench/eeprom_stimulus.txt is missing or empty");
            $display("RESULT: FAIL");
            $finish;
        end
        else
        begin
            loaded = 1'b1;
            apply_reset();
            for (int i = 0; i < n_lines; i++)
                drive_request(i);
            @(negedge CLK);
            req_valid = 1'b0;
            while (rsp_count < req_count)
                @(negedge CLK);
            repeat (40) @(negedge CLK);   // room for a duplicate to show up
            report_and_finish();
        end
    end

    // watchdog
    initial
    begin
        wait (loaded);
        repeat (n_lines * 2000) @(posedge CLK);
        $display("timeout after %0d cycles with %0d of %0d responses",
                 n_lines * 2000, rsp_count, req_count);
        $display("requests %0d responses %0d errors %0d", req_count, rsp_count, err_count);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/eeprom_model.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module eeprom_model #(
    parameter bit PRESENT = 1'b1    // an absent part never acknowledges
) (
    input  logic scl,
    input  logic sda,
    output logic sda_pull
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } mstate_e;

    logic [`DATA_W-1:0] mem [2**`ADDR_W];
    mstate_e            st = M_IDLE;
    logic               scl_q = 1'b1;
    logic               sda_q = 1'b1;
    logic               pull_q = 1'b0;
    logic [3:0]         bit_cnt = '0;
    logic [1:0]         byte_idx = '0;  // 0 control, 1 address, 2 data
    logic [`DATA_W-1:0] sh = '0;
    logic               rw = 1'b0;
    logic [2:0]         blk = '0;
    logic [`ADDR_W-1:0] ptr = '0;

    assign sda_pull = pull_q;

    initial
    begin
        for (int a = 0; a < 2**`ADDR_W; a++)
            mem[a] = 8'(a ^ (a >> 3));
    end

    always @(scl or sda)
    begin
        if (scl && scl_q && (sda != sda_q))
        begin
            // start or stop, SDA moved with SCL high
            if (!sda)
            begin
                st       = M_RX;
                bit_cnt  = '0;
                byte_idx = '0;
            end
            else
                st = M_IDLE;
            pull_q <= 1'b0;
        end
        else if (scl && !scl_q)
        begin
            if (st == M_RX)
            begin
                sh      = {sh[`DATA_W-2:0], sda};
                bit_cnt = bit_cnt + 1'b1;
            end
            else if (st == M_MACK)
                st = M_IDLE;    // single byte reads only
        end
        else if (!scl && scl_q)
        begin
            case (st)
                M_RX:
                begin
                    if (bit_cnt == 4'd8)
                    begin
                        bit_cnt = '0;
                        st      = M_ACK;
                        if (byte_idx == 2'd0)
                        begin
                            if (PRESENT && sh[7:4] == 4'b1010)
                            begin
                                blk = sh[3:1];
                                rw  = sh[0];
                            end
                            else
                                st = M_IDLE;
                        end
                        else if (byte_idx == 2'd1)
                            ptr = {blk, sh};
                        else
                        begin
                            mem[ptr] = sh;      // write completes at once
                            ptr      = ptr + 1'b1;
                        end
                        if (st == M_ACK)
                        begin
                            pull_q  <= 1'b1;
                            byte_idx = byte_idx + 1'b1;
                        end
                    end
                end
                M_ACK:
                begin
                    if (rw && byte_idx == 2'd1)
                    begin
                        sh      = mem[ptr];
                        ptr     = ptr + 1'b1;
                        pull_q <= !sh[`DATA_W-1];
                        bit_cnt = 4'd1;
                        st      = M_TX;
                    end
                    else
                    begin
                        pull_q <= 1'b0;
                        st      = M_RX;
                    end
                end
                M_TX:
                begin
                    if (bit_cnt == 4'd8)
                    begin
                        pull_q <= 1'b0;    // let the master ack
                        st      = M_MACK;
                    end
                    else
                    begin
                        sh      = {sh[`DATA_W-2:0], 1'b0};
                        pull_q <= !sh[`DATA_W-1];
                        bit_cnt = bit_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

// File: design/eeprom_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module eeprom_top
    import eeprom_pkg::*;
(
    input  logic               CLK,
    input  logic               RESET,

    input  logic               req_valid,
    output logic               req_ready,
    input  eeprom_req_t        req,

    output logic               rsp_valid,
    input  logic               rsp_ready,
    output eeprom_rsp_t        rsp,

    output logic [`NUM_CH-1:0] scl,
    output logic [`NUM_CH-1:0] sda_pull,
    input  logic [`NUM_CH-1:0] sda_in
);

    logic [`NUM_CH-1:0]       ch_req_valid;
    logic [`NUM_CH-1:0]       ch_req_ready;
    chan_req_t                ch_req;     // shared by all channels
    logic [`NUM_CH-1:0]       ch_rsp_valid;
    logic [`NUM_CH-1:0]       ch_rsp_ready;
    chan_rsp_t [`NUM_CH-1:0]  ch_rsp;

    eeprom_cmd_dispatch u_dispatch (
        .CLK          (CLK),
        .RESET        (RESET),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .ch_req_valid (ch_req_valid),
        .ch_req_ready (ch_req_ready),
        .ch_req       (ch_req)
    );

    for (genvar i = 0; i < `NUM_CH; i++)
    begin : g_ch
        eeprom_ctrl u_ctrl (
            .CLK       (CLK),
            .RESET     (RESET),
            .req_valid (ch_req_valid[i]),
            .req_ready (ch_req_ready[i]),
            .req       (ch_req),
            .rsp_valid (ch_rsp_valid[i]),
            .rsp_ready (ch_rsp_ready[i]),
            .rsp       (ch_rsp[i]),
            .scl       (scl[i]),
            .sda_pull  (sda_pull[i]),
            .sda_in    (sda_in[i])
        );
    end

    eeprom_resp_collect u_collect (
        .CLK          (CLK),
        .RESET        (RESET),
        .ch_rsp_valid (ch_rsp_valid),
        .ch_rsp_ready (ch_rsp_ready),
        .ch_rsp       (ch_rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp          (rsp)
    );

endmodule

`default_nettype wire

// File: design/eeprom_resp_collect.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module eeprom_resp_collect
    import eeprom_pkg::*;
(
    input  logic                     CLK,
    input  logic                     RESET,

    input  logic [`NUM_CH-1:0]       ch_rsp_valid,
    output logic [`NUM_CH-1:0]       ch_rsp_ready,
    input  chan_rsp_t [`NUM_CH-1:0]  ch_rsp,

    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output eeprom_rsp_t              rsp
);

    logic [`CH_W-1:0] ptr;     // last channel granted
    logic [`CH_W-1:0] gnt_idx;
    logic             gnt_found;
    logic             load_en;

    assign load_en = !rsp_valid || rsp_ready;

    // search starts one past the last grant
    always_comb
    begin
        logic [`CH_W-1:0] idx;
        gnt_found = 1'b0;
        gnt_idx   = ptr;
        for (int k = 1; k <= `NUM_CH; k++)
        begin
            idx = `CH_W'((int'(ptr) + k) % `NUM_CH);
            if (!gnt_found && ch_rsp_valid[idx])
            begin
                gnt_found = 1'b1;
                gnt_idx   = idx;
            end
        end
    end

    always_comb
    begin
        ch_rsp_ready = '0;
        if (load_en && gnt_found)
            ch_rsp_ready[gnt_idx] = 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rsp_valid <= 1'b0;
            ptr       <= `CH_W'(`NUM_CH - 1);   // channel 0 first
        end
        else if (load_en && gnt_found)
        begin
            rsp_valid <= 1'b1;
            ptr       <= gnt_idx;
        end
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (load_en && gnt_found)
        begin
            rsp.chan  <= gnt_idx;
            rsp.rd    <= ch_rsp[gnt_idx].rd;
            rsp.addr  <= ch_rsp[gnt_idx].addr;
            rsp.rdata <= ch_rsp[gnt_idx].rdata;
            rsp.nack  <= ch_rsp[gnt_idx].nack;
        end
    end

    a_rsp_hold: assert property (
        @(posedge CLK) disable iff (RESET)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    )
    else
        $error("response changed under back-pressure");

endmodule

`default_nettype wire

// File: eeprom_ctrl/eeprom_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,

    input  logic      req_valid,
    output logic      req_ready,
    input  chan_req_t req,

    output logic      rsp_valid,
    input  logic      rsp_ready,
    output chan_rsp_t rsp,

    output logic      scl,
    output logic      sda_pull,
    input  logic      sda_in
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_RD,
        S_READ,
        S_STOP,
        S_RESP
    } state_e;

    state_e             state;
    logic               issued;     // command handed to the engine, result pending
    logic               nack_q;
    chan_req_t          req_q;
    logic [`DATA_W-1:0] rdata_q;

    logic               cmd_valid;
    logic               cmd_ready;
    bit_cmd_t           cmd;
    logic               res_valid;
    bit_res_t           res;
    logic [2:0]         blk;

    assign blk = req_q.addr[`ADDR_W-1 -: 3];

    // one bit-engine command per phase
    always_comb
    begin
        cmd.op  = START;
        cmd.tx  = '0;
        cmd.ack = 1'b0;    // single byte read ends with NACK
        case (state)
            S_START,
            S_RSTART:  cmd.op = START;
            S_CTRL:
            begin
                cmd.op = TX_BYTE;
                cmd.tx = {4'b1010, blk, 1'b0};
            end
            S_ADDR:
            begin
                cmd.op = TX_BYTE;
                cmd.tx = req_q.addr[7:0];
            end
            S_DATA:
            begin
                cmd.op = TX_BYTE;
                cmd.tx = req_q.wdata;
            end
            S_CTRL_RD:
            begin
                cmd.op = TX_BYTE;
                cmd.tx = {4'b1010, blk, 1'b1};
            end
            S_READ:    cmd.op = RX_BYTE;
            S_STOP:    cmd.op = STOP;
            default:   cmd.op = START;
        endcase
    end

    assign cmd_valid = (state != S_IDLE) && (state != S_RESP) && !issued;
    assign req_ready = (state == S_IDLE);
    assign rsp_valid = (state == S_RESP);

    assign rsp.rd    = req_q.rd;
    assign rsp.addr  = req_q.addr;
    assign rsp.rdata = rdata_q;
    assign rsp.nack  = nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            issued <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;

            case (state)
                S_IDLE:
                begin
                    if (req_valid)
                    begin
                        req_q   <= req;
                        rdata_q <= '0;
                        nack_q  <= 1'b0;
                        state   <= S_START;
                    end
                end
                S_RESP:
                begin
                    if (rsp_ready)
                        state <= S_IDLE;
                end
                default:
                begin
                    if (res_valid)
                    begin
                        issued <= 1'b0;
                        case (state)
                            S_START:   state <= S_CTRL;
                            S_RSTART:  state <= S_CTRL_RD;
                            S_READ:
                            begin
                                rdata_q <= res.rx;
                                state   <= S_STOP;
                            end
                            S_STOP:    state <= S_RESP;
                            default:   // a sent byte, check the slave ack
                            begin
                                if (!res.ack)
                                begin
                                    nack_q <= 1'b1;
                                    state  <= S_STOP;   // abort
                                end
                                else if (state == S_CTRL)
                                    state <= S_ADDR;
                                else if (state == S_ADDR)
                                    state <= req_q.rd ? S_RSTART : S_DATA;
                                else if (state == S_CTRL_RD)
                                    state <= S_READ;
                                else
                                    state <= S_STOP;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    eeprom_bit_engine u_bit_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .res_valid (res_valid),
        .res       (res),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

    // every command must find the engine idle
    a_no_overlap: assert property (
        @(posedge CLK) disable iff (RESET)
        cmd_valid |-> cmd_ready
    )
    else
        $error("command offered while the bit engine is busy");

endmodule

`default_nettype wire

// File: eeprom_ctrl/eeprom_bit_engine.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module eeprom_bit_engine
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,

    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  bit_cmd_t cmd,

    output logic     res_valid,
    output bit_res_t res,

    output logic     scl,
    output logic     sda_pull,
    input  logic     sda_in
);

    localparam int PERIOD = 2 * `SCL_HALF;
    localparam int CNT_W  = $clog2(PERIOD);

    // positions inside one SCL period, low half first
    localparam logic [CNT_W-1:0] MID_LO = CNT_W'(`SCL_HALF / 2);
    localparam logic [CNT_W-1:0] RISE   = CNT_W'(`SCL_HALF - 1);
    localparam logic [CNT_W-1:0] MID_HI = CNT_W'(`SCL_HALF + `SCL_HALF / 2);
    localparam logic [CNT_W-1:0] LAST   = CNT_W'(PERIOD - 1);

    logic               busy;
    bit_op_e            op_q;
    logic [CNT_W-1:0]   cnt;
    logic [3:0]         bit_cnt;    // 8 is the ack slot
    logic [`DATA_W-1:0] sh;
    logic               mack;
    logic               ack_q;
    logic               last_slot;
    logic               ack_slot;

    assign cmd_ready = !busy;
    assign ack_slot  = (bit_cnt == 4'(`DATA_W));
    assign last_slot = (op_q == START) || (op_q == STOP) || ack_slot;

    assign res.rx  = sh;
    assign res.ack = ack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            cnt       <= '0;
            bit_cnt   <= '0;
            scl       <= 1'b1;    // idle bus
            sda_pull  <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy    <= 1'b1;
                    cnt     <= '0;
                    bit_cnt <= '0;
                    op_q    <= cmd.op;
                    sh      <= cmd.tx;
                    mack    <= cmd.ack;
                    scl     <= 1'b0;
                end
            end
            else
            begin
                cnt <= cnt + 1'b1;
                if (cnt == RISE)
                    scl <= 1'b1;

                if (cnt == MID_LO)    // SDA moves only with SCL low here
                begin
                    case (op_q)
                        START:   sda_pull <= 1'b0;
                        STOP:    sda_pull <= 1'b1;
                        TX_BYTE:
                        begin
                            sda_pull <= ack_slot ? 1'b0 : !sh[`DATA_W-1];
                            if (!ack_slot)
                                sh <= {sh[`DATA_W-2:0], 1'b0};
                        end
                        default: sda_pull <= ack_slot ? mack : 1'b0;
                    endcase
                end

                if (cnt == MID_HI)
                begin
                    case (op_q)
                        START:   sda_pull <= 1'b1;   // SDA falls, SCL high
                        STOP:    sda_pull <= 1'b0;   // SDA rises, SCL high
                        TX_BYTE:
                        begin
                            if (ack_slot)
                                ack_q <= !sda_in;
                        end
                        default:
                        begin
                            if (ack_slot)
                                ack_q <= mack;
                            else
                                sh <= {sh[`DATA_W-2:0], sda_in};
                        end
                    endcase
                end

                if (cnt == LAST)
                begin
                    cnt <= '0;
                    if (last_slot)
                    begin
                        busy      <= 1'b0;    // SCL left high
                        res_valid <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        scl     <= 1'b0;
                    end
                end
            end
        end
    end

    a_sda_stable: assert property (
        @(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(busy && (op_q == START || op_q == STOP)))
            |-> $stable(sda_pull)
    )
    else
        $error("SDA changed while SCL was high");

endmodule

`default_nettype wire

// File: design/eeprom_cmd_dispatch.sv
`default_nettype none
`timescale 1ns/10ps

`include "eeprom_defines.svh"

module eeprom_cmd_dispatch
    import eeprom_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,

    input  logic              req_valid,
    output logic              req_ready,
    input  eeprom_req_t       req,

    output logic [`NUM_CH-1:0] ch_req_valid,
    input  logic [`NUM_CH-1:0] ch_req_ready,
    output chan_req_t         ch_req
);

    // one-hot valid from the channel field
    always_comb
    begin
        ch_req_valid = '0;
        for (int i = 0; i < `NUM_CH; i++)
        begin
            if (req.chan == `CH_W'(i))
                ch_req_valid[i] = req_valid;
        end
    end

    assign req_ready = ch_req_ready[req.chan];   // busy channel stalls the host

    // shared payload, channel field dropped
    assign ch_req.rd    = req.rd;
    assign ch_req.addr  = req.addr;
    assign ch_req.wdata = req.wdata;

    a_one_target: assert property (
        @(posedge CLK) disable iff (RESET)
        $onehot0(ch_req_valid)
    )
    else
        $error("dispatch drives more than one channel valid");

    // host must hold its request while the addressed channel is busy
    a_req_hold: assert property (
        @(posedge CLK) disable iff (RESET)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    )
    else
        $error("host request changed before it was accepted");

endmodule

`default_nettype wire

// File: common/eeprom_pkg.sv
`default_nettype none

`include "eeprom_defines.svh"

package eeprom_pkg;

    typedef struct packed {
        logic               rd;
        logic [`CH_W-1:0]   chan;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic               rd;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } chan_req_t;

    typedef struct packed {
        logic [`CH_W-1:0]   chan;
        logic               rd;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] rdata;
        logic               nack;
    } eeprom_rsp_t;

    typedef struct packed {
        logic               rd;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] rdata;
        logic               nack;
    } chan_rsp_t;

    typedef enum logic [1:0] {
        START,
        STOP,
        TX_BYTE,
        RX_BYTE
    } bit_op_e;

    typedef struct packed {
        bit_op_e            op;
        logic [`DATA_W-1:0] tx;
        logic               ack;    // master ack after RX_BYTE, 1 pulls SDA low
    } bit_cmd_t;

    typedef struct packed {
        logic [`DATA_W-1:0] rx;
        logic               ack;    // 1 when the slave pulled SDA low
    } bit_res_t;

endpackage

`default_nettype wire

// File: common/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// channel count and its index width
`define NUM_CH 4
`define CH_W 2

// byte address into a 2 KB part
`define ADDR_W 11

`define DATA_W 8

// CLK cycles per SCL half period
`define SCL_HALF 4

`endif
